// ==== sim.f ====
+incdir+verilog
+incdir+tb
verilog/fix_stream_pkg.sv
verilog/fix_field_pkg.sv
verilog/fix_scan_if.sv
verilog/fix_field_if.sv
verilog/fix_word_scanner.sv
verilog/fix_field_splitter.sv
verilog/fix_field_collector.sv
verilog/fix_parser_top.sv
tb/fix_parser_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# compile and run the FIX parser testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f --top-module fix_parser_tb -o simv --Mdir obj_dir > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/simv > sim.log 2>&1 || echo "simulator returned an error status" >> sim.log

cat sim.log

grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; } \
	|| grep -q "TEST OK" sim.log && exit 0 || { echo "no result in log"; exit 1; }

// ==== tb/fix_parser_tasks.svh ====
`ifndef FIX_PARSER_TASKS_SVH
`define FIX_PARSER_TASKS_SVH

typedef struct packed {
	fix_word_t		tag;
	fix_byte_cnt_t	tag_cnt;
	logic			tag_valid;
	logic			tag_open;
	fix_word_t		body;
	fix_byte_cnt_t	body_cnt;
	logic			body_valid;
	logic			body_open;
	logic			error;
	fix_chan_t		chan;
	int				due;		// cycle count when the output is expected
} exp_t;

exp_t				exp_q[$];
fix_lane_state_e	lane_st [`FIX_NUM_CH];
string				got_tag [`FIX_NUM_CH];
string				got_body [`FIX_NUM_CH];
string				exp_tag [`FIX_NUM_CH];
string				exp_body [`FIX_NUM_CH];

task automatic check_word(input string name, input fix_word_t exp, input fix_word_t act);
	checks++;
	if (exp !== act) begin
		$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
		fails++;
	end
endtask

task automatic check_cnt(input string name, input fix_byte_cnt_t exp, input fix_byte_cnt_t act);
	checks++;
	if (exp !== act) begin
		$display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
		fails++;
	end
endtask

task automatic check_chan(input string name, input fix_chan_t exp, input fix_chan_t act);
	checks++;
	if (exp !== act) begin
		$display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
		fails++;
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	checks++;
	if (exp !== act) begin
		$display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
		fails++;
	end
endtask

task automatic check_text(input string name, input string exp, input string act);
	checks++;
	if (exp != act) begin
		$display("CHECK FAILED at %0t: %s expected \"%s\" got \"%s\"", $time, name, exp, act);
		fails++;
	end
endtask

// splitting rule applied byte by byte in stream order
task automatic model_word(input fix_chan_t ch, input fix_word_t w, output exp_t e);
	fix_lane_state_e	cur;
	int					soh;
	int					sep;
	int					len;
	int					tseg;
	int					bseg;
	logic [7:0]			b;
	soh = -1;
	sep = -1;
	for (int i = `FIX_WORD_BYTES - 1; i >= 0; i--) begin
		b = w[8*i +: 8];
		if (b == `FIX_SOH && soh < 0)
			soh = i;
		if (b == `FIX_SEP && sep < 0)
			sep = i;
	end
	e = '0;
	e.chan = ch;
	cur = lane_st[ch];
	len = 0;
	tseg = 0;
	bseg = 0;
	for (int i = `FIX_WORD_BYTES - 1; i >= 0; i--) begin
		b = w[8*i +: 8];
		if (i == soh || (i == sep && cur != FIX_IDLE)) begin
			if (len > 0 && cur == FIX_IN_TAG)
				tseg++;
			if (len > 0 && cur == FIX_IN_BODY)
				bseg++;
			cur = (i == soh) ? FIX_IN_TAG : FIX_IN_BODY;
			len = 0;
		end else begin
			if (cur == FIX_IN_TAG) begin
				e.tag = (e.tag << 8) | fix_word_t'(b);
				e.tag_cnt++;
			end else if (cur == FIX_IN_BODY) begin
				e.body = (e.body << 8) | fix_word_t'(b);
				e.body_cnt++;
			end
			len++;
		end
	end
	if (len > 0 && cur == FIX_IN_TAG)
		tseg++;
	if (len > 0 && cur == FIX_IN_BODY)
		bseg++;
	e.error = (tseg > 1) || (bseg > 1);
	if (e.error) begin
		e.tag_cnt = '0;
		e.body_cnt = '0;
		cur = FIX_IDLE;
	end
	e.tag_valid = e.tag_cnt != '0;
	e.body_valid = e.body_cnt != '0;
	e.tag_open = cur == FIX_IN_TAG;
	e.body_open = cur == FIX_IN_BODY;
	lane_st[ch] = cur;
endtask

task automatic append_frag(inout string s, input fix_word_t v, input fix_byte_cnt_t cnt);
	for (int k = int'(cnt) - 1; k >= 0; k--)
		s = $sformatf("%s%c", s, v[8*k +: 8]);
endtask

// compares the outputs with the oldest expectation, runs on the falling edge
task automatic check_output();
	exp_t	e;
	logic	active;
	active = tag_valid_o | tag_open_o | body_valid_o | body_open_o | error_o;
	while (exp_q.size() > 0 && exp_q[0].due < cyc) begin
		$display("output for channel %0d never arrived at cycle %0d",
			exp_q[0].chan, exp_q[0].due);
		fails++;
		void'(exp_q.pop_front());
	end
	if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
		e = exp_q.pop_front();
		check_bit("tag_valid_o", e.tag_valid, tag_valid_o);
		check_bit("tag_open_o", e.tag_open, tag_open_o);
		check_bit("body_valid_o", e.body_valid, body_valid_o);
		check_bit("body_open_o", e.body_open, body_open_o);
		check_bit("error_o", e.error, error_o);
		check_chan("chan_o", e.chan, chan_o);
		if (e.tag_valid) begin
			check_word("tag_o", e.tag, tag_o);
			check_cnt("tag_cnt_o", e.tag_cnt, tag_cnt_o);
		end
		if (e.body_valid) begin
			check_word("body_o", e.body, body_o);
			check_cnt("body_cnt_o", e.body_cnt, body_cnt_o);
		end
	end else if (active) begin
		$display("unexpected output on channel %0d at time %0t", chan_o, $time);
		fails++;
	end
	if (tag_valid_o)
		append_frag(got_tag[chan_o], tag_o, tag_cnt_o);
	if (body_valid_o)
		append_frag(got_body[chan_o], body_o, body_cnt_o);
endtask

task automatic send_word(input fix_chan_t ch, input fix_word_t w);
	exp_t	e;
	@(negedge clk);
	word_i = w;
	chan_i = ch;
	word_valid_i = 1'b1;
	model_word(ch, w, e);
	e.due = cyc + 3;	// three register stages
	if (e.tag_valid | e.tag_open | e.body_valid | e.body_open | e.error)
		exp_q.push_back(e);
endtask

task automatic go_idle();
	@(negedge clk);
	word_valid_i = 1'b0;
	word_i = '0;
endtask

task automatic wait_drain();
	int	n;
	n = 0;
	while (exp_q.size() > 0 && n < 50) begin
		@(negedge clk);
		n++;
	end
	if (exp_q.size() > 0) begin
		$display("timeout: %0d expected outputs never arrived", exp_q.size());
		fails++;
		exp_q.delete();
	end
	repeat (2) @(negedge clk);
endtask

// '|' stands for SOH in message text
function automatic fix_word_t pack_word(input string m, input int ofs);
	fix_word_t	w;
	logic [7:0]	c;
	w = '0;
	for (int i = 0; i < `FIX_WORD_BYTES; i++) begin
		c = m[ofs + i];
		w = (w << 8) | fix_word_t'((c == "|") ? `FIX_SOH : c);
	end
	return w;
endfunction

task automatic clear_text(input fix_chan_t ch);
	got_tag[ch] = "";
	got_body[ch] = "";
	exp_tag[ch] = "";
	exp_body[ch] = "";
endtask

task automatic expect_text(input fix_chan_t ch, input string m);
	int	mode;
	mode = 0;
	for (int i = 0; i < m.len(); i++) begin
		if (m[i] == "|")
			mode = 1;
		else if (m[i] == "=" && mode == 1)
			mode = 2;
		else if (mode == 1)
			exp_tag[ch] = $sformatf("%s%c", exp_tag[ch], m[i]);
		else if (mode == 2)
			exp_body[ch] = $sformatf("%s%c", exp_body[ch], m[i]);
	end
endtask

task automatic compare_text(input fix_chan_t ch);
	check_text($sformatf("tag text ch%0d", ch), exp_tag[ch], got_tag[ch]);
	check_text($sformatf("body text ch%0d", ch), exp_body[ch], got_body[ch]);
endtask

task automatic report_test(input string name, input int fails_before);
	tests++;
	$display("%-16s %s", name, (fails == fails_before) ? "passed" : "failed");
endtask

task automatic test_reset_idle();
	int	f0;
	f0 = fails;
	check_bit("tag_valid_o", 1'b0, tag_valid_o);
	check_bit("tag_open_o", 1'b0, tag_open_o);
	check_bit("body_valid_o", 1'b0, body_valid_o);
	check_bit("body_open_o", 1'b0, body_open_o);
	check_bit("error_o", 1'b0, error_o);
	send_word(0, pack_word("35=A", 0));		// no soh yet, dropped
	send_word(0, pack_word("BC=D", 0));
	go_idle();
	wait_drain();
	report_test("reset_idle", f0);
endtask

task automatic test_single_word();
	int	f0;
	f0 = fails;
	send_word(1, pack_word("|35=", 0));
	send_word(1, pack_word("A|49", 0));
	send_word(1, pack_word("=XY|", 0));
	send_word(1, pack_word("8=F|", 0));
	send_word(1, pack_word("9=12", 0));
	send_word(1, pack_word("|7=A", 0));
	go_idle();
	wait_drain();
	report_test("single_word", f0);
endtask

task automatic test_multi_word();
	string	m;
	int		f0;
	f0 = fails;
	m = "|123456=ABCDEFGHIJK|987654321=Z|";
	clear_text(2);
	expect_text(2, m);
	for (int i = 0; i < m.len(); i += `FIX_WORD_BYTES)
		send_word(2, pack_word(m, i));
	go_idle();
	wait_drain();
	compare_text(2);
	report_test("multi_word", f0);
endtask

task automatic test_channels();
	string	msg [4];
	string	m [`FIX_NUM_CH];
	int		pos [`FIX_NUM_CH];
	int		left;
	int		n;
	int		f0;
	fix_chan_t	ch;
	f0 = fails;
	msg[0] = "|8=FIX.4.4|35=D|";
	msg[1] = "|35=A|49=BB|";
	msg[2] = "|1=ab|22=cd|";
	msg[3] = "|555=IBMX|44=12|";
	left = 0;
	for (int c = 0; c < `FIX_NUM_CH; c++) begin
		m[c] = msg[c % 4];
		pos[c] = 0;
		clear_text(fix_chan_t'(c));
		expect_text(fix_chan_t'(c), m[c]);
		left += m[c].len() / `FIX_WORD_BYTES;
	end
	n = 0;
	while (left > 0 && n < 1000) begin
		ch = fix_chan_t'($unsigned($random(seed)) % `FIX_NUM_CH);
		if (pos[ch] < m[ch].len()) begin
			send_word(ch, pack_word(m[ch], pos[ch]));
			pos[ch] += `FIX_WORD_BYTES;
			left--;
		end
		n++;
	end
	if (left > 0) begin
		$display("timeout: %0d words were never sent", left);
		fails++;
	end
	go_idle();
	wait_drain();
	for (int c = 0; c < `FIX_NUM_CH; c++)
		compare_text(fix_chan_t'(c));
	report_test("channels", f0);
endtask

task automatic test_error();
	int	f0;
	f0 = fails;
	clear_text(3);
	send_word(3, pack_word("|1=A", 0));
	send_word(3, pack_word("B=C|", 0));		// second body fragment
	send_word(3, pack_word("XY=Z", 0));		// idle, dropped
	send_word(3, pack_word("|7=Q", 0));
	send_word(3, pack_word("RST|", 0));
	go_idle();
	wait_drain();
	check_text("tag text ch3", "17", got_tag[3]);
	check_text("body text ch3", "AQRST", got_body[3]);
	report_test("error", f0);
endtask

task automatic test_pipeline();
	string	m;
	int		f0;
	f0 = fails;
	m = "|10=ABCDEFG|11=HI|12=JKLMNO|";
	for (int i = 0; i < m.len(); i += `FIX_WORD_BYTES)
		send_word(fix_chan_t'((i / `FIX_WORD_BYTES) % 2), pack_word(m, i));
	go_idle();
	wait_drain();
	report_test("pipeline", f0);
endtask

`endif

// ==== tb/fix_parser_tb.sv ====
`default_nettype none

`include "fix_cfg.svh"

module fix_parser_tb
	import fix_stream_pkg::*;
	import fix_field_pkg::*;
();

logic			clk;
logic			arst_n_i;
fix_word_t		word_i;
logic			word_valid_i;
fix_chan_t		chan_i;
fix_word_t		tag_o;
fix_byte_cnt_t	tag_cnt_o;
logic			tag_valid_o;
logic			tag_open_o;
fix_word_t		body_o;
fix_byte_cnt_t	body_cnt_o;
logic			body_valid_o;
logic			body_open_o;
logic			error_o;
fix_chan_t		chan_o;

integer			seed = 32'h23b1ad53;
int				cyc = 0;		// posedge count
int				fails = 0;
int				checks = 0;
int				tests = 0;

fix_parser_top dut0 (
	.clk			(clk),
	.arst_n_i		(arst_n_i),
	.word_i			(word_i),
	.word_valid_i	(word_valid_i),
	.chan_i			(chan_i),
	.tag_o			(tag_o),
	.tag_cnt_o		(tag_cnt_o),
	.tag_valid_o	(tag_valid_o),
	.tag_open_o		(tag_open_o),
	.body_o			(body_o),
	.body_cnt_o		(body_cnt_o),
	.body_valid_o	(body_valid_o),
	.body_open_o	(body_open_o),
	.error_o		(error_o),
	.chan_o			(chan_o)
);

`include "fix_parser_tasks.svh"

initial clk = 1'b0;
always #20 clk = ~clk;

always @(posedge clk)
	cyc <= cyc + 1;

always @(negedge clk) begin
	if (arst_n_i)
		check_output();
end

// hard limit in case a wait loop is broken
initial begin
	for (int i = 0; i < 20000; i++)
		@(posedge clk);
	$display("timeout: simulation did not finish in 20000 cycles");
	$display("TEST FAILED");
	$finish;
end

initial begin
	arst_n_i = 1'b0;
	word_i = '0;
	word_valid_i = 1'b0;
	chan_i = '0;
	for (int c = 0; c < `FIX_NUM_CH; c++) begin
		lane_st[c] = FIX_IDLE;
		clear_text(fix_chan_t'(c));
	end
	repeat (10) @(posedge clk);
	@(negedge clk);
	arst_n_i = 1'b1;

	test_reset_idle();
	test_single_word();
	test_multi_word();
	test_channels();
	test_error();
	test_pipeline();

	$display("tests %0d, checks %0d, failures %0d", tests, checks, fails);
	if (fails == 0)
		$display("TEST OK");
	else
		$display("TEST FAILED");
	$finish;
end

endmodule

`default_nettype wire

// ==== verilog/fix_parser_top.sv ====
`default_nettype none

`include "fix_cfg.svh"

module fix_parser_top
	import fix_stream_pkg::*;
	import fix_field_pkg::*;
(
	input logic				clk,
	input logic				arst_n_i,

	input fix_word_t		word_i,
	input logic				word_valid_i,
	input fix_chan_t		chan_i,

	output fix_word_t		tag_o,
	output fix_byte_cnt_t	tag_cnt_o,
	output logic			tag_valid_o,
	output logic			tag_open_o,
	output fix_word_t		body_o,
	output fix_byte_cnt_t	body_cnt_o,
	output logic			body_valid_o,
	output logic			body_open_o,
	output logic			error_o,
	output fix_chan_t		chan_o
);

fix_scan_if		scan ();
fix_field_if	field [`FIX_NUM_CH] ();

fix_word_scanner scanner0 (
	.clk			(clk),
	.arst_n_i		(arst_n_i),
	.word_i			(word_i),
	.word_valid_i	(word_valid_i),
	.chan_i			(chan_i),
	.scan_o			(scan)
);

for (genvar g = 0; g < `FIX_NUM_CH; g++) begin : g_lane
	fix_field_splitter #(.LANE(g)) lane (
		.clk		(clk),
		.arst_n_i	(arst_n_i),
		.scan_i		(scan),
		.field_o	(field[g])
	);
end

fix_field_collector collector0 (
	.clk			(clk),
	.arst_n_i		(arst_n_i),
	.field_i		(field),
	.tag_o			(tag_o),
	.tag_cnt_o		(tag_cnt_o),
	.tag_valid_o	(tag_valid_o),
	.tag_open_o		(tag_open_o),
	.body_o			(body_o),
	.body_cnt_o		(body_cnt_o),
	.body_valid_o	(body_valid_o),
	.body_open_o	(body_open_o),
	.error_o		(error_o),
	.chan_o			(chan_o)
);

endmodule

`default_nettype wire

// ==== verilog/fix_field_collector.sv ====
`default_nettype none

`include "fix_cfg.svh"

module fix_field_collector
	import fix_stream_pkg::*;
	import fix_field_pkg::*;
(
	input logic				clk,
	input logic				arst_n_i,

	fix_field_if.sink		field_i [`FIX_NUM_CH],

	output fix_word_t		tag_o,
	output fix_byte_cnt_t	tag_cnt_o,
	output logic			tag_valid_o,
	output logic			tag_open_o,
	output fix_word_t		body_o,
	output fix_byte_cnt_t	body_cnt_o,
	output logic			body_valid_o,
	output logic			body_open_o,
	output logic			error_o,
	output fix_chan_t		chan_o
);

logic [`FIX_NUM_CH-1:0]	act;
logic [4:0]				flag_a [`FIX_NUM_CH];	// tag valid/open, body valid/open, error
fix_word_t				tag_a [`FIX_NUM_CH];
fix_word_t				body_a [`FIX_NUM_CH];
fix_byte_cnt_t			tag_cnt_a [`FIX_NUM_CH];
fix_byte_cnt_t			body_cnt_a [`FIX_NUM_CH];
fix_chan_t				sel;

for (genvar g = 0; g < `FIX_NUM_CH; g++) begin : g_lane
	assign flag_a[g] = {field_i[g].tag_valid, field_i[g].tag_open,
		field_i[g].body_valid, field_i[g].body_open, field_i[g].error};
	assign tag_a[g] = field_i[g].tag;
	assign body_a[g] = field_i[g].body;
	assign tag_cnt_a[g] = field_i[g].tag_cnt;
	assign body_cnt_a[g] = field_i[g].body_cnt;
	assign act[g] = |flag_a[g];
end

always_comb begin
	sel = '0;	// lane 0 flags are all low when nothing is active
	for (int i = 0; i < `FIX_NUM_CH; i++) begin
		if (act[i])
			sel = fix_chan_t'(i);
	end
end

always_ff @(posedge clk or negedge arst_n_i) begin
	if (!arst_n_i) begin
		{tag_valid_o, tag_open_o, body_valid_o, body_open_o, error_o} <= '0;
		chan_o <= '0;
	end else begin
		{tag_valid_o, tag_open_o, body_valid_o, body_open_o, error_o} <= flag_a[sel];
		chan_o <= sel;
	end
end

always_ff @(posedge clk) begin
	if (|act) begin
		tag_o <= tag_a[sel];
		tag_cnt_o <= tag_cnt_a[sel];
		body_o <= body_a[sel];
		body_cnt_o <= body_cnt_a[sel];
	end else begin
		tag_o <= '0;
		tag_cnt_o <= '0;
		body_o <= '0;
		body_cnt_o <= '0;
	end
end

// scanner hands each word to one lane only
a_one_lane: assert property (@(posedge clk) disable iff (!arst_n_i) $onehot0(act));

endmodule

`default_nettype wire

// ==== verilog/fix_field_splitter.sv ====
`default_nettype none

`include "fix_cfg.svh"

module fix_field_splitter
	import fix_stream_pkg::*;
	import fix_field_pkg::*;
#(
	parameter int LANE = 0
) (
	input logic			clk,
	input logic			arst_n_i,

	fix_scan_if.sink	scan_i,
	fix_field_if.source	field_o
);

fix_lane_state_e	state;
fix_lane_state_e	state_nxt;
logic				take;
logic				soh_use;
logic				sep_use;
logic				both_use;
logic				soh_last;		// soh is the last delimiter in the word
logic				err;
fix_byte_pos_t		first_pos;
fix_byte_pos_t		last_pos;
fix_byte_cnt_t		pre_lo;
fix_byte_cnt_t		pre_cnt;
fix_byte_cnt_t		mid_lo;
fix_byte_cnt_t		mid_cnt;
fix_byte_cnt_t		tail_cnt;
fix_byte_cnt_t		tag_pre_cnt;
fix_byte_cnt_t		tag_new_cnt;
fix_byte_cnt_t		body_pre_cnt;
fix_byte_cnt_t		body_new_cnt;
fix_byte_cnt_t		tag_lo;
fix_byte_cnt_t		tag_cnt;
fix_byte_cnt_t		body_lo;
fix_byte_cnt_t		body_cnt;
fix_word_t			tag_val;
fix_word_t			body_val;

// bytes [lo, lo+cnt) moved down to bit 0
function automatic fix_word_t align_frag(fix_word_t word, fix_byte_cnt_t lo, fix_byte_cnt_t cnt);
	fix_word_t shifted;
	fix_word_t res;
	shifted = word >> {lo, 3'b000};
	res = '0;
	for (int b = 0; b < `FIX_WORD_BYTES; b++) begin
		if (b < cnt)
			res[8*b +: 8] = shifted[8*b +: 8];
	end
	return res;
endfunction

assign take = scan_i.valid && (scan_i.chan == fix_chan_t'(LANE));

always_comb begin
	soh_use = scan_i.soh_pos != `FIX_POS_NONE;
	sep_use = (scan_i.sep_pos != `FIX_POS_NONE) &&
		((state != FIX_IDLE) || (soh_use && (scan_i.sep_pos < scan_i.soh_pos)));	// idle ignores '=' before soh
	both_use = soh_use && sep_use;
	soh_last = soh_use && (!sep_use || (scan_i.soh_pos < scan_i.sep_pos));

	if (both_use) begin
		first_pos = soh_last ? scan_i.sep_pos : scan_i.soh_pos;
		last_pos = soh_last ? scan_i.soh_pos : scan_i.sep_pos;
	end else begin
		first_pos = soh_use ? scan_i.soh_pos : scan_i.sep_pos;
		last_pos = first_pos;
	end

	// prefix [pre_lo, 4), middle [mid_lo, first), tail [0, last)
	pre_lo = (soh_use || sep_use) ? first_pos + 3'd1 : '0;
	pre_cnt = fix_byte_cnt_t'(`FIX_WORD_BYTES) - pre_lo;
	mid_lo = last_pos + 3'd1;
	mid_cnt = both_use ? first_pos - last_pos - 3'd1 : '0;
	tail_cnt = (soh_use || sep_use) ? last_pos : '0;

	tag_pre_cnt = (state == FIX_IN_TAG) ? pre_cnt : '0;		// prefix continues open field
	body_pre_cnt = (state == FIX_IN_BODY) ? pre_cnt : '0;
	tag_new_cnt = soh_last ? tail_cnt : mid_cnt;
	body_new_cnt = soh_last ? mid_cnt : tail_cnt;

	err = ((tag_pre_cnt != '0) && (tag_new_cnt != '0)) ||
		((body_pre_cnt != '0) && (body_new_cnt != '0));

	if (tag_pre_cnt != '0) begin
		tag_lo = pre_lo;
		tag_cnt = tag_pre_cnt;
	end else begin
		tag_lo = soh_last ? '0 : mid_lo;
		tag_cnt = tag_new_cnt;
	end

	if (body_pre_cnt != '0) begin
		body_lo = pre_lo;
		body_cnt = body_pre_cnt;
	end else begin
		body_lo = soh_last ? mid_lo : '0;
		body_cnt = body_new_cnt;
	end

	if (err) begin
		tag_cnt = '0;
		body_cnt = '0;
	end

	tag_val = align_frag(scan_i.word, tag_lo, tag_cnt);
	body_val = align_frag(scan_i.word, body_lo, body_cnt);

	if (err)
		state_nxt = FIX_IDLE;
	else if (soh_use || sep_use)
		state_nxt = soh_last ? FIX_IN_TAG : FIX_IN_BODY;
	else
		state_nxt = state;
end

always_ff @(posedge clk or negedge arst_n_i) begin
	if (!arst_n_i) begin
		state <= FIX_IDLE;
		field_o.tag_valid <= 1'b0;
		field_o.tag_open <= 1'b0;
		field_o.body_valid <= 1'b0;
		field_o.body_open <= 1'b0;
		field_o.error <= 1'b0;
	end else begin
		if (take)
			state <= state_nxt;
		field_o.tag_valid <= take && !err && ((tag_pre_cnt != '0) || (tag_new_cnt != '0));
		field_o.body_valid <= take && !err && ((body_pre_cnt != '0) || (body_new_cnt != '0));
		field_o.tag_open <= take && (state_nxt == FIX_IN_TAG);		// field open at word end
		field_o.body_open <= take && (state_nxt == FIX_IN_BODY);
		field_o.error <= take && err;
	end
end

always_ff @(posedge clk) begin
	if (take) begin
		field_o.tag <= tag_val;
		field_o.tag_cnt <= tag_cnt;
		field_o.body <= body_val;
		field_o.body_cnt <= body_cnt;
	end
end

a_cnt_max: assert property (@(posedge clk) disable iff (!arst_n_i)
	(field_o.tag_valid || field_o.body_valid) |->
	((field_o.tag_cnt <= 3'd4) && (field_o.body_cnt <= 3'd4)));

a_valid_cnt: assert property (@(posedge clk) disable iff (!arst_n_i)
	(!field_o.tag_valid || (field_o.tag_cnt != '0)) &&
	(!field_o.body_valid || (field_o.body_cnt != '0)));

endmodule

`default_nettype wire

// ==== verilog/fix_word_scanner.sv ====
`default_nettype none

`include "fix_cfg.svh"

module fix_word_scanner
	import fix_stream_pkg::*;
(
	input logic			clk,
	input logic			arst_n_i,
	input fix_word_t	word_i,
	input logic			word_valid_i,
	input fix_chan_t	chan_i,

	fix_scan_if.source	scan_o
);

fix_byte_pos_t		soh_pos;
fix_byte_pos_t		sep_pos;

// higher index comes first on the wire, so the last hit in the loop wins
always_comb begin
	soh_pos = `FIX_POS_NONE;
	sep_pos = `FIX_POS_NONE;
	for (int i = 0; i < `FIX_WORD_BYTES; i++) begin
		if (word_i[8*i +: 8] == `FIX_SOH)
			soh_pos = fix_byte_pos_t'(i);
		if (word_i[8*i +: 8] == `FIX_SEP)
			sep_pos = fix_byte_pos_t'(i);
	end
end

always_ff @(posedge clk or negedge arst_n_i) begin
	if (!arst_n_i)
		scan_o.valid <= 1'b0;
	else
		scan_o.valid <= word_valid_i;
end

always_ff @(posedge clk) begin
	if (word_valid_i) begin
		scan_o.word <= word_i;
		scan_o.soh_pos <= soh_pos;
		scan_o.sep_pos <= sep_pos;
		scan_o.chan <= chan_i;
	end
end

// a word for a missing lane would vanish without trace
a_chan_range: assert property (@(posedge clk) disable iff (!arst_n_i)
	word_valid_i |-> (int'(chan_i) < `FIX_NUM_CH));

endmodule

`default_nettype wire

// ==== verilog/fix_field_if.sv ====
`default_nettype none

interface fix_field_if import fix_stream_pkg::*; import fix_field_pkg::*; ();

	fix_word_t		tag;
	fix_byte_cnt_t	tag_cnt;
	logic			tag_valid;
	logic			tag_open;	// tag field continues into next word

	fix_word_t		body;
	fix_byte_cnt_t	body_cnt;
	logic			body_valid;
	logic			body_open;

	logic			error;

	modport source (
		output tag, tag_cnt, tag_valid, tag_open,
		output body, body_cnt, body_valid, body_open, error
	);

	modport sink (
		input tag, tag_cnt, tag_valid, tag_open,
		input body, body_cnt, body_valid, body_open, error
	);

endinterface

`default_nettype wire

// ==== verilog/fix_scan_if.sv ====
`default_nettype none

interface fix_scan_if import fix_stream_pkg::*; ();

	fix_word_t		word;
	fix_byte_pos_t	soh_pos;	// first soh in stream order
	fix_byte_pos_t	sep_pos;	// first '='
	fix_chan_t		chan;
	logic			valid;		// one cycle strobe

	modport source (
		output word, soh_pos, sep_pos, chan, valid
	);

	modport sink (
		input word, soh_pos, sep_pos, chan, valid
	);

endinterface

`default_nettype wire

// ==== verilog/fix_field_pkg.sv ====
`default_nettype none

package fix_field_pkg;

	typedef logic [2:0]		fix_byte_cnt_t;		// fragment length 0..4

	typedef enum logic [1:0] {
		FIX_IDLE	= 2'd0,		// before first soh or after error
		FIX_IN_TAG	= 2'd1,
		FIX_IN_BODY	= 2'd2
	} fix_lane_state_e;

endpackage

`default_nettype wire

// ==== verilog/fix_stream_pkg.sv ====
`default_nettype none

`include "fix_cfg.svh"

package fix_stream_pkg;

	// input word, also used for right aligned fragments
	typedef logic [8*`FIX_WORD_BYTES-1:0]	fix_word_t;

	// index 3 is the first byte on the wire
	typedef logic [2:0]						fix_byte_pos_t;		// 0..3 or FIX_POS_NONE

	typedef logic [$clog2(`FIX_NUM_CH)-1:0]	fix_chan_t;

endpackage

`default_nettype wire

// ==== verilog/fix_cfg.svh ====
`ifndef FIX_CFG_SVH
`define FIX_CFG_SVH

// stream layout
`define FIX_NUM_CH		4		// streams and lanes, 2 or 8 also fine
`define FIX_WORD_BYTES	4		// first byte in bits 31..24

// delimiter codes
`define FIX_SOH			8'h01
`define FIX_SEP			8'h3D	// '='

`define FIX_POS_NONE	3'b111	// no delimiter in word

`endif
